// File: common/exu_cfg.svh
// widths and reset values shared by the execute stage RTL and its testbench
// include wherever a width or a control reset value is needed

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data and address width
`define EXU_XLEN    64

// register file address width
`define EXU_REG_AW  5

// width of the decoded function field
`define EXU_FUNC_W  4

// reset value of the stage control flops
`define EXU_CTRL_RST 1'b0

`endif

// File: common/exu_pkg.sv
// instruction class, ALU operation and branch condition types for the
// execute stage, plus the function field that decode hands over

`include "exu_cfg.svh"

package exu_pkg;

    // what the stage does with an instruction
    typedef enum logic [2:0] {
        cls_alu    = 3'd0,
        cls_load   = 3'd1,
        cls_branch = 3'd2,
        cls_jal    = 3'd3,
        cls_jalr   = 3'd4
    } exu_class_e;

    typedef enum logic [`EXU_FUNC_W-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        br_eq = 2'd0,
        br_ne = 2'd1,
        br_lt = 2'd2,
        br_ge = 2'd3
    } br_cond_e;

    typedef struct packed {
        logic     is_signed;
        br_cond_e cond;
        logic     spare;
    } br_func_t;

    // alu class reads the op, branch class reads the compare fields
    typedef union packed {
        alu_op_e  alu;
        br_func_t br;
    } exu_func_u;

endpackage

// File: exu/branch_unit.sv
// branch compare and jump/branch target adder
// taken is only meaningful for the branch class, target for any redirect

`timescale 1ns/1ps
`include "exu_cfg.svh"

module branch_unit (
    input  exu_pkg::exu_class_e    op_class,
    input  exu_pkg::exu_func_u     func,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   src1,
    input  logic [`EXU_XLEN-1:0]   src2,
    input  logic [`EXU_XLEN-1:0]   imm,
    output logic                   taken,
    output logic [`EXU_XLEN-1:0]   target
);

    logic                 is_eq;
    logic                 is_lt;
    logic                 cond_met;
    logic [`EXU_XLEN-1:0] base;
    logic [`EXU_XLEN-1:0] sum;

    assign is_eq = (src1 == src2);
    assign is_lt = func.br.is_signed ? ($signed(src1) < $signed(src2)) : (src1 < src2);

    always_comb begin
        case (func.br.cond)
            exu_pkg::br_eq: cond_met = is_eq;
            exu_pkg::br_ne: cond_met = !is_eq;
            exu_pkg::br_lt: cond_met = is_lt;
            exu_pkg::br_ge: cond_met = !is_lt;
            default:        cond_met = 1'b0;
        endcase
    end

    assign taken = (op_class == exu_pkg::cls_branch) && cond_met;

    // jalr is register relative, everything else pc relative
    assign base = (op_class == exu_pkg::cls_jalr) ? src1 : pc;
    assign sum  = base + imm;

    // bit 0 always cleared
    assign target = sum & ~{{(`EXU_XLEN-1){1'b0}}, 1'b1};

endmodule

// File: exu/exu_alu.sv
// integer ALU of the execute stage
// gives the result for alu ops, the load address and the jal/jalr link value

`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu (
    input  exu_pkg::exu_class_e    op_class,
    input  exu_pkg::exu_func_u     func,
    input  logic [`EXU_XLEN-1:0]   src1,
    input  logic [`EXU_XLEN-1:0]   src2,
    input  logic [`EXU_XLEN-1:0]   imm,
    input  logic [`EXU_XLEN-1:0]   next_pc,
    input  logic                   use_imm,
    output logic [`EXU_XLEN-1:0]   alu_result
);

    logic [`EXU_XLEN-1:0] op2;
    logic [5:0]           shamt;
    logic [`EXU_XLEN-1:0] op_result;

    assign op2   = use_imm ? imm : src2;
    assign shamt = op2[5:0];

    // ************************************************************************
    // register/immediate operations
    // ************************************************************************
    always_comb begin
        case (func.alu)
            exu_pkg::op_add:  op_result = src1 + op2;
            exu_pkg::op_sub:  op_result = src1 - op2;
            exu_pkg::op_and:  op_result = src1 & op2;
            exu_pkg::op_or:   op_result = src1 | op2;
            exu_pkg::op_xor:  op_result = src1 ^ op2;
            exu_pkg::op_sll:  op_result = src1 << shamt;
            exu_pkg::op_srl:  op_result = src1 >> shamt;
            exu_pkg::op_sra:  op_result = $signed(src1) >>> shamt;
            exu_pkg::op_slt: begin
                op_result = {{(`EXU_XLEN-1){1'b0}}, $signed(src1) < $signed(op2)};
            end
            exu_pkg::op_sltu: begin
                op_result = {{(`EXU_XLEN-1){1'b0}}, src1 < op2};
            end
            default:          op_result = '0;
        endcase
    end

    // ************************************************************************
    // result by class
    // ************************************************************************
    always_comb begin
        case (op_class)
            exu_pkg::cls_alu:  alu_result = op_result;
            // effective address toward load/store
            exu_pkg::cls_load: alu_result = src1 + imm;
            // link value
            exu_pkg::cls_jal,
            exu_pkg::cls_jalr: alu_result = next_pc;
            default:           alu_result = '0;
        endcase
    end

endmodule

// File: exu/exu_stage.sv
// stage controller of the execute stage
// owns the handshake toward decode, the single-pulse redirect to fetch and
// the output register toward the load/store unit

`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   decode_valid,
    input  logic                   flush,
    input  logic                   ls_ready,
    input  logic                   load_use,
    input  exu_pkg::exu_class_e    op_class,
    input  logic                   taken,
    input  logic [`EXU_XLEN-1:0]   target,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   next_pc,
    input  logic [`EXU_REG_AW-1:0] rd,
    input  logic                   dest_wen,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    output logic                   decode_ready,
    output logic                   jump_flag,
    output logic [`EXU_XLEN-1:0]   jump_addr,
    output logic                   ex_valid,
    output logic [`EXU_XLEN-1:0]   ex_pc,
    output logic [`EXU_XLEN-1:0]   ex_next_pc,
    output logic [`EXU_REG_AW-1:0] ex_rd,
    output logic                   ex_dest_wen,
    output logic                   ex_load,
    output logic [`EXU_XLEN-1:0]   ex_result
);

    logic redirect;
    logic slot_free;
    logic accept;
    logic jump_done;

    assign redirect  = (op_class == exu_pkg::cls_jal) ||
                       (op_class == exu_pkg::cls_jalr) || taken;
    assign slot_free = !ex_valid || ls_ready;

    assign decode_ready = decode_valid && slot_free && !flush && !load_use;
    assign accept       = decode_valid && decode_ready;

    // ************************************************************************
    // redirect toward fetch
    // ************************************************************************
    assign jump_flag = decode_valid && redirect && !load_use && !jump_done;
    assign jump_addr = target;

    // remembers a redirect already sent while the instruction waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_done <= `EXU_CTRL_RST;
        end else if (flush || accept) begin
            jump_done <= 1'b0;
        end else if (jump_flag) begin
            jump_done <= 1'b1;
        end
    end

    // ************************************************************************
    // output register toward load/store
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= `EXU_CTRL_RST;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (accept) begin
            ex_valid <= 1'b1;
        end else if (slot_free) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pc       <= pc;
            ex_next_pc  <= redirect ? target : next_pc;
            ex_rd       <= rd;
            ex_dest_wen <= dest_wen;
            ex_load     <= (op_class == exu_pkg::cls_load);
            ex_result   <= alu_result;
        end
    end

endmodule

// File: exu/exu_top.sv
// top level of the execute stage
// forwarding and the two datapath units feed the stage controller

`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // decode
    input  logic                   decode_valid,
    output logic                   decode_ready,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   next_pc,
    input  logic [`EXU_REG_AW-1:0] rs1,
    input  logic [`EXU_REG_AW-1:0] rs2,
    input  logic [`EXU_XLEN-1:0]   rs1_data,
    input  logic [`EXU_XLEN-1:0]   rs2_data,
    input  logic [`EXU_XLEN-1:0]   imm,
    input  logic                   use_imm,
    input  logic [`EXU_REG_AW-1:0] rd,
    input  logic                   dest_wen,
    input  exu_pkg::exu_class_e    op_class,
    input  exu_pkg::exu_func_u     func,
    // load/store
    output logic                   ex_valid,
    output logic [`EXU_XLEN-1:0]   ex_pc,
    output logic [`EXU_XLEN-1:0]   ex_next_pc,
    output logic [`EXU_REG_AW-1:0] ex_rd,
    output logic                   ex_dest_wen,
    output logic                   ex_load,
    output logic [`EXU_XLEN-1:0]   ex_result,
    input  logic                   ls_ready,
    input  logic                   flush,
    // write-back
    input  logic                   wb_valid,
    input  logic [`EXU_REG_AW-1:0] wb_rd,
    input  logic                   wb_dest_wen,
    input  logic [`EXU_XLEN-1:0]   wb_data,
    // fetch
    output logic                   jump_flag,
    output logic [`EXU_XLEN-1:0]   jump_addr
);

    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic                 load_use;
    logic [`EXU_XLEN-1:0] alu_result;
    logic                 taken;
    logic [`EXU_XLEN-1:0] target;

    operand_fwd fwd_i (
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_result   (ex_result),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_dest_wen (ex_dest_wen),
        .ex_load     (ex_load),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_dest_wen (wb_dest_wen),
        .src1        (src1),
        .src2        (src2),
        .load_use    (load_use)
    );

    exu_alu alu_i (
        .op_class   (op_class),
        .func       (func),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .next_pc    (next_pc),
        .use_imm    (use_imm),
        .alu_result (alu_result)
    );

    branch_unit br_i (
        .op_class (op_class),
        .func     (func),
        .pc       (pc),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .taken    (taken),
        .target   (target)
    );

    exu_stage stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .decode_valid (decode_valid),
        .flush        (flush),
        .ls_ready     (ls_ready),
        .load_use     (load_use),
        .op_class     (op_class),
        .taken        (taken),
        .target       (target),
        .pc           (pc),
        .next_pc      (next_pc),
        .rd           (rd),
        .dest_wen     (dest_wen),
        .alu_result   (alu_result),
        .decode_ready (decode_ready),
        .jump_flag    (jump_flag),
        .jump_addr    (jump_addr),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_next_pc   (ex_next_pc),
        .ex_rd        (ex_rd),
        .ex_dest_wen  (ex_dest_wen),
        .ex_load      (ex_load),
        .ex_result    (ex_result)
    );

endmodule

// File: files.f
+incdir+common
common/exu_pkg.sv
logic/operand_fwd.sv
exu/exu_alu.sv
exu/branch_unit.sv
exu/exu_stage.sv
exu/exu_top.sv
testbench/exu_props.sv
testbench/exu_tb.sv

// File: logic/operand_fwd.sv
// source operand selection for the execute stage
// picks the stage output, the write-back result or the register file value
// and flags a load-use hazard when a load result is not yet available

`timescale 1ns/1ps
`include "exu_cfg.svh"

module operand_fwd (
    input  logic [`EXU_REG_AW-1:0] rs1,
    input  logic [`EXU_REG_AW-1:0] rs2,
    input  logic [`EXU_XLEN-1:0]   rs1_data,
    input  logic [`EXU_XLEN-1:0]   rs2_data,
    input  logic [`EXU_XLEN-1:0]   ex_result,
    input  logic [`EXU_XLEN-1:0]   wb_data,
    input  logic                   ex_valid,
    input  logic [`EXU_REG_AW-1:0] ex_rd,
    input  logic                   ex_dest_wen,
    input  logic                   ex_load,
    input  logic                   wb_valid,
    input  logic [`EXU_REG_AW-1:0] wb_rd,
    input  logic                   wb_dest_wen,
    output logic [`EXU_XLEN-1:0]   src1,
    output logic [`EXU_XLEN-1:0]   src2,
    output logic                   load_use
);

    logic ex_hit1;
    logic ex_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // a producer matches when it really writes a nonzero rd equal to the source
    function automatic logic fwd_hit(
        input logic [`EXU_REG_AW-1:0] rs,
        input logic                   valid,
        input logic [`EXU_REG_AW-1:0] rd,
        input logic                   wen
    );
        return valid && wen && (rd != '0) && (rd == rs);
    endfunction

    assign ex_hit1 = fwd_hit(rs1, ex_valid, ex_rd, ex_dest_wen);
    assign ex_hit2 = fwd_hit(rs2, ex_valid, ex_rd, ex_dest_wen);
    assign wb_hit1 = fwd_hit(rs1, wb_valid, wb_rd, wb_dest_wen);
    assign wb_hit2 = fwd_hit(rs2, wb_valid, wb_rd, wb_dest_wen);

    // youngest producer wins
    assign src1 = ex_hit1 ? ex_result :
                  wb_hit1 ? wb_data   : rs1_data;
    assign src2 = ex_hit2 ? ex_result :
                  wb_hit2 ? wb_data   : rs2_data;

    // stage output holds an address, not the loaded data
    assign load_use = ex_load && (ex_hit1 || ex_hit2);

endmodule

// File: testbench/exu_props.sv
// concurrent checks for the execute stage, bound into exu_top by the testbench
// expected values are rebuilt from the stage rules and the forwarding order
// every failed check bumps err_count, which the testbench watches

`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   decode_valid,
    input logic                   decode_ready,
    input logic [`EXU_XLEN-1:0]   pc,
    input logic [`EXU_XLEN-1:0]   next_pc,
    input logic [`EXU_REG_AW-1:0] rs1,
    input logic [`EXU_REG_AW-1:0] rs2,
    input logic [`EXU_XLEN-1:0]   rs1_data,
    input logic [`EXU_XLEN-1:0]   rs2_data,
    input logic [`EXU_XLEN-1:0]   imm,
    input logic                   use_imm,
    input logic [`EXU_REG_AW-1:0] rd,
    input logic                   dest_wen,
    input exu_pkg::exu_class_e    op_class,
    input exu_pkg::exu_func_u     func,
    input logic                   ex_valid,
    input logic [`EXU_XLEN-1:0]   ex_pc,
    input logic [`EXU_XLEN-1:0]   ex_next_pc,
    input logic [`EXU_REG_AW-1:0] ex_rd,
    input logic                   ex_dest_wen,
    input logic                   ex_load,
    input logic [`EXU_XLEN-1:0]   ex_result,
    input logic                   ls_ready,
    input logic                   flush,
    input logic                   wb_valid,
    input logic [`EXU_REG_AW-1:0] wb_rd,
    input logic                   wb_dest_wen,
    input logic [`EXU_XLEN-1:0]   wb_data,
    input logic                   jump_flag,
    input logic [`EXU_XLEN-1:0]   jump_addr
);

    int unsigned          err_count = 0;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] exp_result;
    logic [`EXU_XLEN-1:0] exp_target;
    logic [`EXU_XLEN-1:0] exp_next_pc;
    logic [`EXU_XLEN-1:0] hold_result;
    logic [`EXU_XLEN-1:0] hold_next_pc;
    logic [`EXU_XLEN-1:0] hold_pc;
    logic [`EXU_REG_AW-1:0] hold_rd;
    logic                 hold_wen;
    logic                 hold_load;
    logic                 exp_taken;
    logic                 exp_redirect;
    logic                 exp_load_use;
    logic                 exp_ready;
    logic                 accept;
    logic                 sent;

    // ************************************************************************
    // reference model of one cycle at decode
    // ************************************************************************
    always_comb begin
        // register file first, later producers override
        a = rs1_data;
        b = rs2_data;
        if (wb_valid && wb_dest_wen && wb_rd != '0) begin
            a = (wb_rd == rs1) ? wb_data : a;
            b = (wb_rd == rs2) ? wb_data : b;
        end
        if (ex_valid && ex_dest_wen && ex_rd != '0) begin
            a = (ex_rd == rs1) ? ex_result : a;
            b = (ex_rd == rs2) ? ex_result : b;
        end
        exp_load_use = ex_valid && ex_dest_wen && ex_load && ex_rd != '0 &&
                       (ex_rd == rs1 || ex_rd == rs2);
        exp_ready    = decode_valid && (!ex_valid || ls_ready) && !flush && !exp_load_use;

        op2        = use_imm ? imm : b;
        exp_result = '0;
        case (op_class)
            exu_pkg::cls_load: exp_result = a + imm;
            exu_pkg::cls_jal,
            exu_pkg::cls_jalr: exp_result = next_pc;
            exu_pkg::cls_alu: begin
                case (func.alu)
                    exu_pkg::op_add:  exp_result = a + op2;
                    exu_pkg::op_sub:  exp_result = a - op2;
                    exu_pkg::op_and:  exp_result = a & op2;
                    exu_pkg::op_or:   exp_result = a | op2;
                    exu_pkg::op_xor:  exp_result = a ^ op2;
                    exu_pkg::op_sll:  exp_result = a << op2[5:0];
                    exu_pkg::op_srl:  exp_result = a >> op2[5:0];
                    exu_pkg::op_sra:  exp_result = $signed(a) >>> op2[5:0];
                    exu_pkg::op_slt:  exp_result[0] = $signed(a) < $signed(op2);
                    exu_pkg::op_sltu: exp_result[0] = a < op2;
                    default:          exp_result = '0;
                endcase
            end
            default: exp_result = '0;
        endcase

        exp_taken = 1'b0;
        case (func.br.cond)
            exu_pkg::br_eq: exp_taken = (a == b);
            exu_pkg::br_ne: exp_taken = (a != b);
            exu_pkg::br_lt: exp_taken = func.br.is_signed ? $signed(a) < $signed(b) : a < b;
            exu_pkg::br_ge: exp_taken = func.br.is_signed ? $signed(a) >= $signed(b) : a >= b;
        endcase
        exp_taken     = exp_taken && (op_class == exu_pkg::cls_branch);
        exp_redirect  = exp_taken || op_class == exu_pkg::cls_jal ||
                        op_class == exu_pkg::cls_jalr;
        exp_target    = ((op_class == exu_pkg::cls_jalr) ? a : pc) + imm;
        exp_target[0] = 1'b0;
        exp_next_pc   = exp_redirect ? exp_target : next_pc;
    end

    assign accept = decode_valid && decode_ready;

    // redirect already sent for the instruction waiting at decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= 1'b0;
        end else if (flush || accept) begin
            sent <= 1'b0;
        end else if (jump_flag) begin
            sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_result  <= exp_result;
            hold_next_pc <= exp_next_pc;
            hold_pc      <= pc;
            hold_rd      <= rd;
            hold_wen     <= dest_wen;
            hold_load    <= (op_class == exu_pkg::cls_load);
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************
    a_reset: assert property (@(posedge clk) !rst_n |-> !ex_valid && !jump_flag)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_valid or jump_flag high during reset", $time);
        end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        decode_ready == exp_ready)
        else begin
            err_count++;
            $error("[FAIL] t=%0t decode_ready exp=%b act=%b",
                   $time, $sampled(exp_ready), $sampled(decode_ready));
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_valid)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_valid low after an accepted instruction", $time);
        end

    a_drain: assert property (@(posedge clk) disable iff (!rst_n)
        !accept && (!ex_valid || ls_ready) |=> !ex_valid)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_valid still high with no new instruction", $time);
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_result == hold_result)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_result exp=%h act=%h",
                   $time, $sampled(hold_result), $sampled(ex_result));
        end

    a_next_pc: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_next_pc == hold_next_pc)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_next_pc exp=%h act=%h",
                   $time, $sampled(hold_next_pc), $sampled(ex_next_pc));
        end

    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_pc == hold_pc)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_pc exp=%h act=%h",
                   $time, $sampled(hold_pc), $sampled(ex_pc));
        end

    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_rd == hold_rd)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_rd exp=%h act=%h",
                   $time, $sampled(hold_rd), $sampled(ex_rd));
        end

    a_wen: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_dest_wen == hold_wen)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_dest_wen exp=%b act=%b",
                   $time, $sampled(hold_wen), $sampled(ex_dest_wen));
        end

    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ex_load == hold_load)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_load exp=%b act=%b",
                   $time, $sampled(hold_load), $sampled(ex_load));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !ls_ready && !flush |=> ex_valid &&
            $stable({ex_pc, ex_next_pc, ex_rd, ex_dest_wen, ex_load, ex_result}))
        else begin
            err_count++;
            $error("[FAIL] t=%0t stage output changed while load/store stalled", $time);
        end

    a_jump: assert property (@(posedge clk) disable iff (!rst_n)
        jump_flag == (decode_valid && exp_redirect && !exp_load_use && !sent))
        else begin
            err_count++;
            $error("[FAIL] t=%0t jump_flag exp=%b act=%b", $time,
                   $sampled(decode_valid && exp_redirect && !exp_load_use && !sent),
                   $sampled(jump_flag));
        end

    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        jump_flag |-> jump_addr == exp_target)
        else begin
            err_count++;
            $error("[FAIL] t=%0t jump_addr exp=%h act=%h",
                   $time, $sampled(exp_target), $sampled(jump_addr));
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ex_valid)
        else begin
            err_count++;
            $error("[FAIL] t=%0t ex_valid still high after flush", $time);
        end

endmodule

// File: testbench/exu_tb.sv
// testbench for the execute stage
// drives directed and random instructions into exu_top with a register file
// and write-back model around it; the bound exu_props module does the checking

`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_tb;

    localparam int PERIOD      = 100;
    localparam int N_RANDOM    = 30;
    localparam int MARGIN      = 20;
    localparam int STIM_CYCLES = 3 + 2 * 10 + 24 + 2 + 6 + 3 + 2 + 7 + 3 + 2 * N_RANDOM + 5;

    logic                   clk;
    logic                   rst_n;
    logic                   decode_valid;
    logic                   decode_ready;
    logic [`EXU_XLEN-1:0]   pc;
    logic [`EXU_XLEN-1:0]   next_pc;
    logic [`EXU_REG_AW-1:0] rs1;
    logic [`EXU_REG_AW-1:0] rs2;
    logic [`EXU_XLEN-1:0]   rs1_data;
    logic [`EXU_XLEN-1:0]   rs2_data;
    logic [`EXU_XLEN-1:0]   imm;
    logic                   use_imm;
    logic [`EXU_REG_AW-1:0] rd;
    logic                   dest_wen;
    exu_pkg::exu_class_e    op_class;
    exu_pkg::exu_func_u     func;
    logic                   ex_valid;
    logic [`EXU_XLEN-1:0]   ex_pc;
    logic [`EXU_XLEN-1:0]   ex_next_pc;
    logic [`EXU_REG_AW-1:0] ex_rd;
    logic                   ex_dest_wen;
    logic                   ex_load;
    logic [`EXU_XLEN-1:0]   ex_result;
    logic                   ls_ready;
    logic                   flush;
    logic                   wb_valid;
    logic [`EXU_REG_AW-1:0] wb_rd;
    logic                   wb_dest_wen;
    logic [`EXU_XLEN-1:0]   wb_data;
    logic                   jump_flag;
    logic [`EXU_XLEN-1:0]   jump_addr;

    logic [`EXU_XLEN-1:0]   regs [0:(1 << `EXU_REG_AW)-1];
    logic [`EXU_XLEN-1:0]   cur_pc;
    logic [31:0]            rnd;
    int                     seed;

    exu_top dut_i (.*);

    bind exu_top exu_props props_i (.*);

    // register file read outside the stage
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // memory contents seen by loads, a pattern over the whole address
    function automatic logic [`EXU_XLEN-1:0] load_data(input logic [`EXU_XLEN-1:0] addr);
        return {addr[31:0], addr[63:32]} ^ (addr * 64'd3) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    // ************************************************************************
    // write-back stage and register file
    // ************************************************************************
    always @(posedge clk) begin
        wb_valid    <= ex_valid && ls_ready && rst_n;
        wb_rd       <= ex_rd;
        wb_dest_wen <= ex_dest_wen;
        wb_data     <= ex_load ? load_data(ex_result) : ex_result;
        if (wb_valid && wb_dest_wen && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // present one instruction and hold it until decode takes it
    task automatic issue(
        input exu_pkg::exu_class_e    cls,
        input logic [3:0]             fn,
        input logic [`EXU_REG_AW-1:0] src_a,
        input logic [`EXU_REG_AW-1:0] src_b,
        input logic [`EXU_REG_AW-1:0] dst,
        input logic                   with_imm
    );
        logic took;
        decode_valid <= 1'b1;
        op_class     <= cls;
        func         <= fn;
        rs1          <= src_a;
        rs2          <= src_b;
        rd           <= dst;
        dest_wen     <= (cls != exu_pkg::cls_branch);
        use_imm      <= with_imm;
        imm          <= {$random(seed), $random(seed)};
        pc           <= cur_pc;
        next_pc      <= cur_pc + 4;
        cur_pc = cur_pc + 4;
        do begin
            @(negedge clk);
            took = decode_ready;
            @(posedge clk);
        end while (!took);
    endtask

    task automatic idle(input int cycles);
        decode_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        wait (dut_i.props_i.err_count != 0);
        $display("*** TEST FAILED ***");
        $fatal(1, "an execute stage check failed, see the error above");
    end

    initial begin
        #((STIM_CYCLES + MARGIN) * PERIOD);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired before the stimulus finished");
    end

    initial begin
        seed         = 32'h9031;
        rst_n        = 1'b0;
        decode_valid = 1'b0;
        pc           = '0;
        next_pc      = '0;
        rs1          = '0;
        rs2          = '0;
        imm          = '0;
        use_imm      = 1'b0;
        rd           = '0;
        dest_wen     = 1'b0;
        op_class     = exu_pkg::cls_alu;
        func         = '0;
        ls_ready     = 1'b1;
        flush        = 1'b0;
        wb_valid     = 1'b0;
        wb_rd        = '0;
        wb_dest_wen  = 1'b0;
        wb_data      = '0;
        cur_pc       = 64'h0000_0000_8000_0000;
        for (int i = 0; i < (1 << `EXU_REG_AW); i++) begin
            regs[i] = (i == 0) ? '0 : {$random(seed), $random(seed)};
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // every alu op, register and immediate forms
        for (int op = 0; op < 10; op++) begin
            issue(exu_pkg::cls_alu, 4'(op), 5'd1, 5'd2, 5'(1 + op % 7), 1'b0);
            issue(exu_pkg::cls_alu, 4'(op), 5'd3, 5'd4, 5'(1 + op % 5), 1'b1);
        end

        // each compare kind, unsigned and signed, equal operands and both orders
        for (int k = 0; k < 8; k++) begin
            issue(exu_pkg::cls_branch, 4'({k[2:0], 1'b0}), 5'd3, 5'd3, 5'd0, 1'b0);
            issue(exu_pkg::cls_branch, 4'({k[2:0], 1'b0}), 5'd4, 5'd6, 5'd0, 1'b0);
            issue(exu_pkg::cls_branch, 4'({k[2:0], 1'b0}), 5'd6, 5'd4, 5'd0, 1'b0);
        end

        issue(exu_pkg::cls_jal, 4'd0, 5'd1, 5'd2, 5'd1, 1'b0);
        issue(exu_pkg::cls_jalr, 4'd0, 5'd7, 5'd2, 5'd2, 1'b0);

        // load then dependent alu op and dependent branch
        issue(exu_pkg::cls_load, 4'd0, 5'd2, 5'd0, 5'd5, 1'b1);
        issue(exu_pkg::cls_alu, exu_pkg::op_add, 5'd5, 5'd3, 5'd6, 1'b0);
        issue(exu_pkg::cls_load, 4'd0, 5'd3, 5'd0, 5'd7, 1'b1);
        issue(exu_pkg::cls_branch, {1'b0, exu_pkg::br_ne, 1'b0}, 5'd1, 5'd7, 5'd0, 1'b0);

        // x0 written by the stage, then read
        issue(exu_pkg::cls_alu, exu_pkg::op_add, 5'd1, 5'd2, 5'd0, 1'b0);
        issue(exu_pkg::cls_alu, exu_pkg::op_or, 5'd0, 5'd0, 5'd3, 1'b0);
        issue(exu_pkg::cls_alu, exu_pkg::op_xor, 5'd0, 5'd5, 5'd4, 1'b0);

        // back-pressure with a jump waiting at decode
        idle(2);
        ls_ready <= 1'b0;
        issue(exu_pkg::cls_alu, exu_pkg::op_sub, 5'd1, 5'd2, 5'd8, 1'b0);
        fork
            issue(exu_pkg::cls_jal, 4'd0, 5'd9, 5'd9, 5'd9, 1'b0);
            begin
                repeat (5) @(posedge clk);
                ls_ready <= 1'b1;
            end
        join

        // flush with a valid stage output
        issue(exu_pkg::cls_alu, exu_pkg::op_and, 5'd1, 5'd2, 5'd10, 1'b0);
        fork
            begin
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end
            issue(exu_pkg::cls_branch, {1'b1, exu_pkg::br_lt, 1'b0}, 5'd4, 5'd6, 5'd0, 1'b0);
        join

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            issue(exu_pkg::exu_class_e'(rnd[31:29] % 3'd5), 4'(rnd[7:0] % 10),
                  5'(rnd[12:8] % 8), 5'(rnd[17:13] % 8), 5'(rnd[22:18] % 8), rnd[23]);
        end
        idle(5);

        if (dut_i.props_i.err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
